//--- fp_format_pkg.sv
package fp_format_pkg;

    localparam int EXP_W = 8;
    localparam int MANT_W = 23;
    localparam int BIAS = 127;
    localparam int EXP_ALL_ONES = (1 << EXP_W) - 1;

    typedef logic [EXP_W-1:0] exp_t;
    typedef logic [MANT_W-1:0] mant_t;

    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
    } fp_t;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_snan;
        logic is_normal;
    } fp_class_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_e;

    // negative sign, quiet bit only
    localparam fp_t QNAN_DEFAULT = 32'hFFC0_0000;

    ////////////////////
    // operand class
    ////////////////////

    // zero exponent counts as zero, subnormals are flushed
    function automatic fp_class_t classify(input fp_t x);
        fp_class_t cls;
        logic      exp_max;
        exp_max = (x.exp == exp_t'(EXP_ALL_ONES));
        cls.is_zero = (x.exp == '0);
        cls.is_inf = exp_max && (x.mant == '0);
        cls.is_nan = exp_max && (x.mant != '0);
        // signalling when the quiet bit is clear
        cls.is_snan = cls.is_nan && !x.mant[MANT_W-1];
        cls.is_normal = !cls.is_zero && !exp_max;
        return cls;
    endfunction

endpackage

//--- fma_pkg.sv
package fma_pkg;

    localparam int PROD_W = 2 * (fp_format_pkg::MANT_W + 1);
    // carry, product frame, guard and sticky
    localparam int SUM_W = PROD_W + 3;
    // round bit position once the sum is shifted to its top bit
    localparam int RND_POS = SUM_W - 2 - fp_format_pkg::MANT_W;
    localparam int PROD_LZ_W = $clog2(PROD_W + 1);
    localparam int SUM_LZ_W = $clog2(SUM_W + 1);
    localparam int ALIGN_SH_W = $clog2(PROD_W + 2);

    typedef logic signed [9:0] wide_exp_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [SUM_W-1:0] sum_t;

    typedef struct packed {
        logic               is_special;
        logic               invalid;
        fp_format_pkg::fp_t value;
    } special_t;

    typedef struct packed {
        logic                       sign;
        wide_exp_t                  exp;
        prod_t                      prod;
        special_t                   special;
        fp_format_pkg::fp_t         c;
        fp_format_pkg::fp_class_t   c_class;
        logic                       sub;
        fp_format_pkg::round_mode_e rnd;
    } mul_stage_t;

    typedef struct packed {
        logic                       sign;
        wide_exp_t                  exp;
        sum_t                       sum;
        logic                       sticky;
        special_t                   special;
        fp_format_pkg::round_mode_e rnd;
    } add_stage_t;

    typedef struct packed {
        fp_format_pkg::fp_t result;
        logic [1:0]         rs;
        logic               round_en;
        logic               invalid;
        logic               ovf;
        logic               uf;
    } fma_result_t;

endpackage

//--- lzc.sv
`timescale 1ns/100ps

module lzc #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]               in_i,
    output logic [$clog2(WIDTH+1)-1:0]     cnt_o
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    // scan from lsb up, the highest set bit wins
    always_comb
    begin
        cnt_o = CNT_W'(WIDTH);
        for (int i = 0; i < WIDTH; i++)
        begin
            if (in_i[i])
            begin
                cnt_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

endmodule

//--- fma_mul_stage.sv
`timescale 1ns/100ps

module fma_mul_stage (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  fp_format_pkg::fp_t         a_i,
    input  fp_format_pkg::fp_t         b_i,
    input  fp_format_pkg::fp_t         c_i,
    input  logic                       sub_i,
    input  fp_format_pkg::round_mode_e rnd_i,
    output logic                       valid_o,
    output fma_pkg::mul_stage_t        stage_o
);

    fp_format_pkg::fp_class_t        a_cls;
    fp_format_pkg::fp_class_t        b_cls;
    fp_format_pkg::fp_class_t        c_cls;
    logic [fp_format_pkg::MANT_W:0]  a_sig;
    logic [fp_format_pkg::MANT_W:0]  b_sig;
    fma_pkg::prod_t                  prod_raw;
    logic [fma_pkg::PROD_LZ_W-1:0]   prod_lz;
    logic                            prod_sign;
    logic                            c_sign_eff;
    fma_pkg::special_t               special;
    fma_pkg::mul_stage_t             stage_d;

    assign a_cls = fp_format_pkg::classify(a_i);
    assign b_cls = fp_format_pkg::classify(b_i);
    assign c_cls = fp_format_pkg::classify(c_i);

    assign prod_sign = a_i.sign ^ b_i.sign;
    assign c_sign_eff = c_i.sign ^ sub_i;

    ////////////////////
    // significand product
    ////////////////////
    assign a_sig = a_cls.is_normal ? {1'b1, a_i.mant} : '0;
    assign b_sig = b_cls.is_normal ? {1'b1, b_i.mant} : '0;
    assign prod_raw = a_sig * b_sig;

    // shift the product so its leading one sits on the top bit
    lzc #(.WIDTH(fma_pkg::PROD_W)) u_prod_lzc (
        .in_i  (prod_raw),
        .cnt_o (prod_lz)
    );

    ////////////////////
    // special results
    ////////////////////
    always_comb
    begin
        special = '0;
        special.invalid = a_cls.is_snan | b_cls.is_snan | c_cls.is_snan;
        if (a_cls.is_nan | b_cls.is_nan | c_cls.is_nan)
        begin
            special.is_special = 1'b1;
            special.value = a_cls.is_nan ? a_i : (b_cls.is_nan ? b_i : c_i);
            special.value.mant[fp_format_pkg::MANT_W-1] = 1'b1;
        end
        else if ((a_cls.is_inf & b_cls.is_zero) | (a_cls.is_zero & b_cls.is_inf))
        begin
            special.is_special = 1'b1;
            special.invalid = 1'b1;
            special.value = fp_format_pkg::QNAN_DEFAULT;
        end
        else if (a_cls.is_inf | b_cls.is_inf)
        begin
            special.is_special = 1'b1;
            if (c_cls.is_inf && (prod_sign != c_sign_eff))
            begin
                // inf - inf
                special.invalid = 1'b1;
                special.value = fp_format_pkg::QNAN_DEFAULT;
            end
            else
            begin
                special.value.sign = prod_sign;
                special.value.exp = '1;
            end
        end
        else if (c_cls.is_inf)
        begin
            special.is_special = 1'b1;
            special.value.sign = c_sign_eff;
            special.value.exp = '1;
        end
        else if ((a_cls.is_zero | b_cls.is_zero) & c_cls.is_zero)
        begin
            special.is_special = 1'b1;
            special.value.sign = (prod_sign == c_sign_eff) ? prod_sign
                                                           : (rnd_i == fp_format_pkg::RDN);
        end
    end

    always_comb
    begin
        stage_d.sign = prod_sign;
        // biased exponent of the normalized product
        stage_d.exp = fma_pkg::wide_exp_t'(a_i.exp) + fma_pkg::wide_exp_t'(b_i.exp)
                    - fma_pkg::wide_exp_t'(fp_format_pkg::BIAS - 1)
                    - fma_pkg::wide_exp_t'(prod_lz);
        stage_d.prod = prod_raw << prod_lz;
        stage_d.special = special;
        stage_d.c = c_i;
        stage_d.c_class = c_cls;
        stage_d.sub = sub_i;
        stage_d.rnd = rnd_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_o <= 1'b0;
        else
            valid_o <= start_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (start_i)
            stage_o <= stage_d;
    end

endmodule

//--- fma_add_stage.sv
`timescale 1ns/100ps

module fma_add_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  fma_pkg::mul_stage_t stage_i,
    output logic                valid_o,
    output fma_pkg::add_stage_t stage_o
);

    logic                           c_sign_eff;
    logic                           p_zero;
    logic                           c_zero;
    logic                           p_big;
    logic                           eff_sub;
    logic                           lost;
    fma_pkg::wide_exp_t             c_exp;
    fma_pkg::wide_exp_t             diff;
    fma_pkg::prod_t                 c_sig;
    fma_pkg::prod_t                 big_sig;
    fma_pkg::prod_t                 small_sig;
    logic [fma_pkg::ALIGN_SH_W-1:0] sh;
    logic [fma_pkg::PROD_W:0]       small_ext;
    logic [fma_pkg::PROD_W:0]       small_shr;
    fma_pkg::sum_t                  big_f;
    fma_pkg::sum_t                  small_f;
    fma_pkg::add_stage_t            stage_d;

    assign c_sign_eff = stage_i.c.sign ^ stage_i.sub;
    assign eff_sub = stage_i.sign ^ c_sign_eff;

    // c placed in the product frame, leading one on the top bit
    assign c_zero = !stage_i.c_class.is_normal;
    assign c_sig = c_zero ? '0 : {1'b1, stage_i.c.mant, {(fma_pkg::PROD_W/2){1'b0}}};
    assign c_exp = fma_pkg::wide_exp_t'(stage_i.c.exp);
    assign p_zero = (stage_i.prod == '0);

    ////////////////////
    // magnitude swap
    ////////////////////
    always_comb
    begin
        if (c_zero)
            p_big = 1'b1;
        else if (p_zero)
            p_big = 1'b0;
        else
            p_big = (stage_i.exp > c_exp) ||
                    ((stage_i.exp == c_exp) && (stage_i.prod >= c_sig));
    end

    assign big_sig = p_big ? stage_i.prod : c_sig;
    assign small_sig = p_big ? c_sig : stage_i.prod;
    assign diff = p_big ? (stage_i.exp - c_exp) : (c_exp - stage_i.exp);

    ////////////////////
    // align and add
    ////////////////////

    // out of range shifts push everything into sticky
    always_comb
    begin
        if ((diff < 0) || (diff > fma_pkg::PROD_W + 1))
            sh = fma_pkg::ALIGN_SH_W'(fma_pkg::PROD_W + 1);
        else
            sh = diff[fma_pkg::ALIGN_SH_W-1:0];
    end

    assign small_ext = {small_sig, 1'b0};
    assign small_shr = small_ext >> sh;
    assign lost = |(small_ext & ~({(fma_pkg::PROD_W+1){1'b1}} << sh));

    // bit 0 holds only sticky so a subtract never rounds up
    assign big_f = {1'b0, big_sig, 2'b00};
    assign small_f = {1'b0, small_shr, lost};

    always_comb
    begin
        stage_d.sign = p_big ? stage_i.sign : c_sign_eff;
        stage_d.exp = p_big ? stage_i.exp : c_exp;
        stage_d.sum = eff_sub ? (big_f - small_f) : (big_f + small_f);
        stage_d.sticky = lost;
        stage_d.special = stage_i.special;
        stage_d.rnd = stage_i.rnd;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (valid_i)
            stage_o <= stage_d;
    end

endmodule

//--- fma_norm_stage.sv
`timescale 1ns/100ps

module fma_norm_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  fma_pkg::add_stage_t  stage_i,
    output logic                 done_o,
    output fma_pkg::fma_result_t res_o
);

    logic [fma_pkg::SUM_LZ_W-1:0] lz;
    fma_pkg::sum_t                norm;
    fma_pkg::wide_exp_t           exp_n;
    fma_pkg::fma_result_t         res_d;

    ////////////////////
    // normalize
    ////////////////////
    lzc #(.WIDTH(fma_pkg::SUM_W)) u_sum_lzc (
        .in_i  (stage_i.sum),
        .cnt_o (lz)
    );

    // leading one moves to the carry position, exponent follows
    assign norm = stage_i.sum << lz;
    assign exp_n = stage_i.exp + fma_pkg::wide_exp_t'(1) - fma_pkg::wide_exp_t'(lz);

    ////////////////////
    // result select
    ////////////////////
    always_comb
    begin
        res_d = '0;
        if (stage_i.special.is_special)
        begin
            res_d.result = stage_i.special.value;
            res_d.invalid = stage_i.special.invalid;
        end
        else if (stage_i.sum == '0)
        begin
            // exact cancellation
            res_d.result.sign = (stage_i.rnd == fp_format_pkg::RDN);
        end
        else if (exp_n >= fp_format_pkg::EXP_ALL_ONES)
        begin
            res_d.result.sign = stage_i.sign;
            res_d.result.exp = '1;
            res_d.ovf = 1'b1;
        end
        else if (exp_n <= 0)
        begin
            // below normal range, flush
            res_d.result.sign = stage_i.sign;
            res_d.uf = 1'b1;
        end
        else
        begin
            res_d.result.sign = stage_i.sign;
            res_d.result.exp = exp_n[fp_format_pkg::EXP_W-1:0];
            res_d.result.mant = norm[fma_pkg::RND_POS+1 +: fp_format_pkg::MANT_W];
            res_d.rs[1] = norm[fma_pkg::RND_POS];
            res_d.rs[0] = (|norm[fma_pkg::RND_POS-1:0]) | stage_i.sticky;
            res_d.round_en = 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            done_o <= 1'b0;
        else
            done_o <= valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (valid_i)
            res_o <= res_d;
    end

endmodule

//--- fma_unit.sv
`timescale 1ns/100ps

module fma_unit (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  fp_format_pkg::fp_t         a_i,
    input  fp_format_pkg::fp_t         b_i,
    input  fp_format_pkg::fp_t         c_i,
    input  logic                       sub_i,
    input  fp_format_pkg::round_mode_e rnd_i,
    output logic                       done_o,
    output fma_pkg::fma_result_t       res_o
);

    logic                mul_valid;
    fma_pkg::mul_stage_t mul_stage;
    logic                add_valid;
    fma_pkg::add_stage_t add_stage;

    // stage 1, classify and multiply
    fma_mul_stage u_mul_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (start_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .c_i     (c_i),
        .sub_i   (sub_i),
        .rnd_i   (rnd_i),
        .valid_o (mul_valid),
        .stage_o (mul_stage)
    );

    // stage 2, align and add
    fma_add_stage u_add_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (mul_valid),
        .stage_i (mul_stage),
        .valid_o (add_valid),
        .stage_o (add_stage)
    );

    // stage 3, normalize and flag
    fma_norm_stage u_norm_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (add_valid),
        .stage_i (add_stage),
        .done_o  (done_o),
        .res_o   (res_o)
    );

endmodule

//--- fma_unit_sva.sv
`timescale 1ns/100ps

module fma_unit_sva (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 start_i,
    input fp_format_pkg::fp_t   a_i,
    input fp_format_pkg::fp_t   b_i,
    input fp_format_pkg::fp_t   c_i,
    input logic                 done_i,
    input fma_pkg::fma_result_t res_i
);

    int unsigned fail_cnt = 0;
    logic        nan_in;

    assign nan_in = ((a_i.exp == '1) && (a_i.mant != '0)) ||
                    ((b_i.exp == '1) && (b_i.mant != '0)) ||
                    ((c_i.exp == '1) && (c_i.mant != '0));

    ////////////////////
    // strobe timing
    ////////////////////

    // three register stages
    done_latency_a : assert property (@(posedge clk_i) disable iff (rst_i)
        done_i == $past(start_i, 3))
    else
    begin
        $error("done_o does not follow start_i by three cycles");
        fail_cnt++;
    end

    done_in_reset_a : assert property (@(posedge clk_i) rst_i |=> !done_i)
    else
    begin
        $error("done_o high during reset");
        fail_cnt++;
    end

    done_after_reset_a : assert property (@(posedge clk_i) $fell(rst_i) |=> !done_i)
    else
    begin
        $error("done_o high right after reset");
        fail_cnt++;
    end

    ////////////////////
    // flag invariants
    ////////////////////

    invalid_qnan_a : assert property (@(posedge clk_i) disable iff (rst_i)
        done_i && res_i.invalid |->
            (res_i.result.exp == '1) && res_i.result.mant[fp_format_pkg::MANT_W-1])
    else
    begin
        $error("invalid without a quiet NaN result");
        fail_cnt++;
    end

    // no NaN operand, so the default NaN
    invalid_default_a : assert property (@(posedge clk_i) disable iff (rst_i)
        done_i && res_i.invalid && !$past(nan_in, 3) |->
            res_i.result == fp_format_pkg::QNAN_DEFAULT)
    else
    begin
        $error("invalid operation without the default NaN");
        fail_cnt++;
    end

    ovf_inf_a : assert property (@(posedge clk_i) disable iff (rst_i)
        done_i && res_i.ovf |-> (res_i.result.exp == '1) && (res_i.result.mant == '0))
    else
    begin
        $error("ovf without an infinite result");
        fail_cnt++;
    end

    // round_en only on a finite normal result
    round_en_valid_a : assert property (@(posedge clk_i) disable iff (rst_i)
        done_i && res_i.round_en |->
            !res_i.invalid && !res_i.ovf && !res_i.uf &&
            (res_i.result.exp != '0) && (res_i.result.exp != '1))
    else
    begin
        $error("round_en set on a result outside the normal finite range");
        fail_cnt++;
    end

endmodule

bind fma_unit fma_unit_sva i_fma_unit_sva (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (start_i),
    .a_i     (a_i),
    .b_i     (b_i),
    .c_i     (c_i),
    .done_i  (done_o),
    .res_i   (res_o)
);

//--- tb_fma_unit.sv
`timescale 1ns/100ps

module tb_fma_unit;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 4;
    localparam int N_EXACT = 120;
    localparam int N_STICKY = 60;
    localparam int N_NAN = 40;
    localparam int N_INVALID = 32;
    localparam int N_RANGE = 20;
    localparam int N_OPS = N_EXACT + N_STICKY + N_NAN + N_INVALID + 3 * N_RANGE;
    // idle gaps between groups and pipeline drain
    localparam int WD_MARGIN = 64;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       start = 1'b0;
    fp_format_pkg::fp_t         op_a = '0;
    fp_format_pkg::fp_t         op_b = '0;
    fp_format_pkg::fp_t         op_c = '0;
    logic                       sub = 1'b0;
    fp_format_pkg::round_mode_e rnd = fp_format_pkg::RNE;
    logic                       done;
    fma_pkg::fma_result_t       res;

    fma_pkg::fma_result_t exp_q[$];
    fma_pkg::fma_result_t head;
    int                   errors = 0;
    int                   checked = 0;
    int                   issued = 0;
    int                   sva_errs = 0;

    fma_unit i_fma_unit (
        .clk_i   (clk),
        .rst_i   (rst),
        .start_i (start),
        .a_i     (op_a),
        .b_i     (op_b),
        .c_i     (op_c),
        .sub_i   (sub),
        .rnd_i   (rnd),
        .done_o  (done),
        .res_o   (res)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // expected values
    ////////////////////

    function automatic int msb_of(input longint m);
        int pos;
        pos = 0;
        for (int i = 0; i < 63; i++)
        begin
            if (m[i])
                pos = i;
        end
        return pos;
    endfunction

    // exact encoding, magnitude below 2^24
    function automatic fp_format_pkg::fp_t int_to_fp(input longint v);
        fp_format_pkg::fp_t f;
        longint             m;
        int                 pos;
        f = '0;
        m = (v < 0) ? -v : v;
        pos = msb_of(m);
        if (v != 0)
        begin
            f.sign = (v < 0);
            f.exp = fp_format_pkg::exp_t'(fp_format_pkg::BIAS + pos);
            f.mant = fp_format_pkg::mant_t'(m << (fp_format_pkg::MANT_W - pos));
        end
        return f;
    endfunction

    function automatic fma_pkg::fma_result_t make_res(input fp_format_pkg::fp_t r,
                                                      input logic [1:0] rs,
                                                      input logic round_en,
                                                      input logic inv,
                                                      input logic ovf,
                                                      input logic uf);
        fma_pkg::fma_result_t e;
        e.result = r;
        e.rs = rs;
        e.round_en = round_en;
        e.invalid = inv;
        e.ovf = ovf;
        e.uf = uf;
        return e;
    endfunction

    function automatic logic rand_bit();
        return 1'($urandom % 2);
    endfunction

    function automatic longint rand_int();
        longint m;
        m = 1 + longint'($urandom % 1023);
        return rand_bit() ? -m : m;
    endfunction

    function automatic fp_format_pkg::round_mode_e rand_rnd();
        return fp_format_pkg::round_mode_e'($urandom % 5);
    endfunction

    function automatic fp_format_pkg::fp_t rand_normal();
        fp_format_pkg::fp_t f;
        f = fp_format_pkg::fp_t'($urandom);
        f.exp = fp_format_pkg::exp_t'(1 + $urandom % 254);
        return f;
    endfunction

    function automatic fp_format_pkg::fp_t rand_nan(input logic quiet);
        fp_format_pkg::fp_t f;
        f = fp_format_pkg::fp_t'($urandom);
        f.exp = '1;
        f.mant[fp_format_pkg::MANT_W-1] = quiet;
        if (f.mant == '0)
            f.mant[0] = 1'b1;
        return f;
    endfunction

    ////////////////////
    // drive and check
    ////////////////////

    task automatic issue(input fp_format_pkg::fp_t a, input fp_format_pkg::fp_t b,
                         input fp_format_pkg::fp_t c, input logic s,
                         input fp_format_pkg::round_mode_e r,
                         input fma_pkg::fma_result_t e);
        @(posedge clk);
        start <= 1'b1;
        op_a <= a;
        op_b <= b;
        op_c <= c;
        sub <= s;
        rnd <= r;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic go_idle();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        assert (got_v === exp_v)
        else
        begin
            $display("ERR %s exp=%h got=%h", name, exp_v, got_v);
            errors++;
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst && done)
        begin
            if (exp_q.size() == 0)
            begin
                $display("done_o came with no operation pending");
                errors++;
            end
            else
            begin
                head = exp_q.pop_front();
                check_field("res_o.result", head.result, res.result);
                check_field("res_o.rs", 32'(head.rs), 32'(res.rs));
                check_field("res_o.round_en", 32'(head.round_en), 32'(res.round_en));
                check_field("res_o.invalid", 32'(head.invalid), 32'(res.invalid));
                check_field("res_o.ovf", 32'(head.ovf), 32'(res.ovf));
                check_field("res_o.uf", 32'(head.uf), 32'(res.uf));
                checked++;
            end
        end
    end

    ////////////////////
    // stimulus groups
    ////////////////////

    // small integers, back to back
    task automatic run_exact();
        longint                     a;
        longint                     b;
        longint                     c;
        longint                     v;
        logic                       s;
        fp_format_pkg::round_mode_e r;
        fp_format_pkg::fp_t         z;
        fma_pkg::fma_result_t       e;
        for (int n = 0; n < N_EXACT; n++)
        begin
            a = rand_int();
            b = rand_int();
            c = rand_int();
            s = rand_bit();
            r = rand_rnd();
            v = s ? (a * b - c) : (a * b + c);
            z = '0;
            z.sign = (r == fp_format_pkg::RDN);
            if (v == 0)
                e = make_res(z, 2'b00, 1'b0, 1'b0, 1'b0, 1'b0);
            else
                e = make_res(int_to_fp(v), 2'b00, 1'b1, 1'b0, 1'b0, 1'b0);
            issue(int_to_fp(a), int_to_fp(b), int_to_fp(c), s, r, e);
        end
        go_idle();
    endtask

    // c far below the last product bit lands only in sticky
    task automatic run_sticky();
        longint               a;
        longint               b;
        longint               p;
        int                   d;
        logic                 s;
        fp_format_pkg::fp_t   c;
        fp_format_pkg::fp_t   pf;
        fma_pkg::fma_result_t e;
        for (int n = 0; n < N_STICKY; n++)
        begin
            a = rand_int();
            b = rand_int();
            p = a * b;
            pf = int_to_fp(p);
            d = 30 + int'($urandom % 31);
            c = '0;
            c.sign = rand_bit();
            c.exp = fp_format_pkg::exp_t'(fp_format_pkg::BIAS + msb_of(p < 0 ? -p : p) - d);
            s = rand_bit();
            if ((c.sign ^ s) == pf.sign)
                e = make_res(pf, 2'b01, 1'b1, 1'b0, 1'b0, 1'b0);
            else
                e = make_res(fp_format_pkg::fp_t'(pf - 32'd1), 2'b11, 1'b1, 1'b0, 1'b0, 1'b0);
            issue(int_to_fp(a), int_to_fp(b), c, s, rand_rnd(), e);
        end
        go_idle();
    endtask

    task automatic run_nan();
        int                 kind [3];
        fp_format_pkg::fp_t op [3];
        fp_format_pkg::fp_t first;
        logic               any_snan;
        logic               found;
        for (int n = 0; n < N_NAN; n++)
        begin
            // 0 normal, 1 quiet, 2 signalling
            for (int i = 0; i < 3; i++)
                kind[i] = int'($urandom % 3);
            if ((kind[0] == 0) && (kind[1] == 0) && (kind[2] == 0))
                kind[2] = 1 + int'($urandom % 2);
            any_snan = 1'b0;
            found = 1'b0;
            first = '0;
            for (int i = 0; i < 3; i++)
            begin
                op[i] = (kind[i] == 0) ? rand_normal() : rand_nan(kind[i] == 1);
                any_snan = any_snan | (kind[i] == 2);
                if ((kind[i] != 0) && !found)
                begin
                    first = op[i];
                    found = 1'b1;
                end
            end
            first.mant[fp_format_pkg::MANT_W-1] = 1'b1;
            issue(op[0], op[1], op[2], rand_bit(), rand_rnd(),
                  make_res(first, 2'b00, 1'b0, any_snan, 1'b0, 1'b0));
        end
        go_idle();
    endtask

    task automatic run_invalid();
        fp_format_pkg::fp_t   inf_op;
        fp_format_pkg::fp_t   x;
        fp_format_pkg::fp_t   c;
        logic                 s;
        fma_pkg::fma_result_t e;
        e = make_res(fp_format_pkg::QNAN_DEFAULT, 2'b00, 1'b0, 1'b1, 1'b0, 1'b0);
        for (int n = 0; n < N_INVALID; n++)
        begin
            inf_op = '0;
            inf_op.sign = rand_bit();
            inf_op.exp = '1;
            if (n % 2 == 0)
            begin
                // inf times zero, mantissa ignored under a zero exponent
                x = '0;
                x.sign = rand_bit();
                x.mant = fp_format_pkg::mant_t'($urandom);
                c = rand_normal();
                if (n % 4 == 2)
                    c = {rand_bit(), 8'hFF, 23'h0};
                s = rand_bit();
            end
            else
            begin
                // infinite product minus an infinity of the same sign
                x = rand_normal();
                c = '0;
                c.exp = '1;
                c.sign = inf_op.sign ^ x.sign;
                s = 1'b1;
            end
            if (rand_bit())
                issue(inf_op, x, c, s, rand_rnd(), e);
            else
                issue(x, inf_op, c, s, rand_rnd(), e);
        end
        go_idle();
    endtask

    task automatic run_range();
        longint                     a;
        longint                     b;
        int                         ea;
        int                         eb;
        fp_format_pkg::fp_t         fa;
        fp_format_pkg::fp_t         fb;
        fp_format_pkg::fp_t         c;
        fp_format_pkg::fp_t         z;
        fp_format_pkg::round_mode_e r;
        for (int n = 0; n < N_RANGE; n++)
        begin
            // exact cancellation
            a = rand_int();
            b = rand_int();
            r = rand_rnd();
            z = '0;
            z.sign = (r == fp_format_pkg::RDN);
            issue(int_to_fp(a), int_to_fp(b), int_to_fp(a * b), 1'b1, r,
                  make_res(z, 2'b00, 1'b0, 1'b0, 1'b0, 1'b0));
            // exponent sum at least 383
            ea = 192 + int'($urandom % 63);
            eb = 254 - int'($urandom % (ea - 128));
            fa = rand_normal();
            fb = rand_normal();
            fa.exp = fp_format_pkg::exp_t'(ea);
            fb.exp = fp_format_pkg::exp_t'(eb);
            z = '0;
            z.sign = fa.sign ^ fb.sign;
            z.exp = '1;
            issue(fa, fb, int_to_fp(rand_int()), rand_bit(), rand_rnd(),
                  make_res(z, 2'b00, 1'b0, 1'b0, 1'b1, 1'b0));
            // exponent sum at most 126, c zero
            ea = 1 + int'($urandom % 62);
            eb = 1 + int'($urandom % (126 - ea));
            fa.exp = fp_format_pkg::exp_t'(ea);
            fb.exp = fp_format_pkg::exp_t'(eb);
            c = '0;
            c.sign = rand_bit();
            z = '0;
            z.sign = fa.sign ^ fb.sign;
            issue(fa, fb, c, rand_bit(), rand_rnd(),
                  make_res(z, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1));
        end
        go_idle();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        void'($urandom(32659));
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        run_exact();
        run_sticky();
        run_nan();
        run_invalid();
        run_range();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        sva_errs = i_fma_unit.i_fma_unit_sva.fail_cnt;
        $display("checked %0d of %0d, scoreboard errors %0d, assertion errors %0d",
                 checked, issued, errors, sva_errs);
        if ((errors == 0) && (sva_errs == 0) && (checked == issued))
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * (N_OPS + RST_CYCLES + WD_MARGIN));
        $display("timeout: done_o not seen");
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- compile.f
fp_format_pkg.sv
fma_pkg.sv
lzc.sv
fma_mul_stage.sv
fma_add_stage.sv
fma_norm_stage.sv
fma_unit.sv
fma_unit_sva.sv
tb_fma_unit.sv

//--- run.sh
#!/bin/sh
# build and run the FMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fma_unit -f compile.f \
    --Mdir obj_dir -o sim_fma_unit

./obj_dir/sim_fma_unit +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
